// ==== decodeStage.sv ====
`default_nettype none

module decodeStage (
  input var logic clk,
  input var logic reset,
  input var pipePkg::fetchDecodeT fetched,
  input var pipePkg::writebackT regWrite,
  input var logic regWriteValid,
  output pipePkg::decodeExecuteT decoded,
  output isaPkg::regIndexT rs1,
  output isaPkg::regIndexT rs2
);

  isaPkg::wordT instr;
  isaPkg::wordT rs1Value;
  isaPkg::wordT rs2Value;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic usesRs1;
  logic usesRs2;
  pipePkg::decodeExecuteT ctrl;

  assign instr = fetched.instruction;
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    ctrl = '0;
    ctrl.pc = fetched.pc;
    ctrl.rd = instr[11:7];
    ctrl.aluOp = isaPkg::aluAdd;
    usesRs1 = 1'b0;
    usesRs2 = 1'b0;
    case (isaPkg::opcodeT'(instr[6:0]))
      isaPkg::opcodeOp: begin
        usesRs1 = 1'b1;
        usesRs2 = 1'b1;
        ctrl.writesReg = 1'b1;
        case ({funct7, funct3})
          {isaPkg::funct7Base, isaPkg::funct3AddSub}: ctrl.aluOp = isaPkg::aluAdd;
          {isaPkg::funct7Sub, isaPkg::funct3AddSub}: ctrl.aluOp = isaPkg::aluSub;
          {isaPkg::funct7Base, isaPkg::funct3And}: ctrl.aluOp = isaPkg::aluAnd;
          {isaPkg::funct7Base, isaPkg::funct3Or}: ctrl.aluOp = isaPkg::aluOr;
          {isaPkg::funct7Base, isaPkg::funct3Xor}: ctrl.aluOp = isaPkg::aluXor;
          default: ctrl.writesReg = 1'b0; // shifts and compares are no-ops here.
        endcase
      end
      isaPkg::opcodeOpImm: begin
        usesRs1 = 1'b1;
        ctrl.useImm = 1'b1;
        ctrl.imm = {{20{instr[31]}}, instr[31:20]};
        ctrl.writesReg = funct3 == isaPkg::funct3AddSub; // only ADDI.
      end
      isaPkg::opcodeLui: begin
        ctrl.useImm = 1'b1;
        ctrl.imm = {instr[31:12], 12'b0};
        ctrl.aluOp = isaPkg::aluPassB;
        ctrl.writesReg = 1'b1;
      end
      isaPkg::opcodeLoad: begin
        usesRs1 = 1'b1;
        ctrl.useImm = 1'b1;
        ctrl.imm = {{20{instr[31]}}, instr[31:20]};
        ctrl.isLoad = funct3 == isaPkg::funct3Word;
        ctrl.writesReg = ctrl.isLoad;
      end
      isaPkg::opcodeStore: begin
        usesRs1 = 1'b1;
        usesRs2 = 1'b1;
        ctrl.useImm = 1'b1;
        ctrl.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        ctrl.isStore = funct3 == isaPkg::funct3Word;
      end
      isaPkg::opcodeBranch: begin
        usesRs1 = 1'b1;
        usesRs2 = 1'b1;
        ctrl.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        ctrl.isBranch = funct3 == isaPkg::funct3Beq || funct3 == isaPkg::funct3Bne;
        ctrl.branchOnEqual = funct3 == isaPkg::funct3Beq;
      end
      isaPkg::opcodeJal: begin
        ctrl.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
        ctrl.isJump = 1'b1;
        ctrl.writesReg = 1'b1;
      end
      default: ;
    endcase
  end

  // an unused source reads as x0 so that it never looks like a hazard.
  assign rs1 = usesRs1 ? instr[19:15] : '0;
  assign rs2 = usesRs2 ? instr[24:20] : '0;

  registerFile registerFile_i (
    .clk(clk),
    .reset(reset),
    .rs1(rs1),
    .rs2(rs2),
    .rs1Value(rs1Value),
    .rs2Value(rs2Value),
    .write(regWrite),
    .writeValid(regWriteValid)
  );

  always_comb begin
    decoded = ctrl;
    decoded.rs1 = rs1;
    decoded.rs2 = rs2;
    decoded.rs1Value = rs1Value;
    decoded.rs2Value = rs2Value;
  end

endmodule

`default_nettype wire

// ==== executeStage.sv ====
`default_nettype none

module executeStage (
  input var pipePkg::decodeExecuteT decoded,
  input var pipePkg::forwardSelT rs1Forward,
  input var pipePkg::forwardSelT rs2Forward,
  input var isaPkg::wordT memoryValue,
  input var isaPkg::wordT writebackValue,
  input var logic inValid,
  output pipePkg::executeMemoryT result,
  output pipePkg::redirectT redirect
);

  isaPkg::wordT operandA;
  isaPkg::wordT rs2Operand;
  isaPkg::wordT operandB;
  isaPkg::wordT aluOut;
  logic equal;

  function automatic isaPkg::wordT pickOperand(
    pipePkg::forwardSelT sel,
    isaPkg::wordT regValue,
    isaPkg::wordT fromMem,
    isaPkg::wordT fromWb
  );
    case (sel)
      pipePkg::fromMemory: return fromMem;
      pipePkg::fromWriteback: return fromWb;
      default: return regValue;
    endcase
  endfunction

  assign operandA = pickOperand(rs1Forward, decoded.rs1Value, memoryValue, writebackValue);
  assign rs2Operand = pickOperand(rs2Forward, decoded.rs2Value, memoryValue, writebackValue);
  assign operandB = decoded.useImm ? decoded.imm : rs2Operand;

  always_comb begin
    case (decoded.aluOp)
      isaPkg::aluSub: aluOut = operandA - operandB;
      isaPkg::aluAnd: aluOut = operandA & operandB;
      isaPkg::aluOr: aluOut = operandA | operandB;
      isaPkg::aluXor: aluOut = operandA ^ operandB;
      isaPkg::aluPassB: aluOut = operandB;
      default: aluOut = operandA + operandB;
    endcase
  end

  assign equal = operandA == rs2Operand;

  always_comb begin
    result.aluResult = decoded.isJump ? decoded.pc + 32'd4 : aluOut; // link value for JAL.
    result.storeValue = rs2Operand;
    result.rd = decoded.rd;
    result.writesReg = decoded.writesReg;
    result.isLoad = decoded.isLoad;
    result.isStore = decoded.isStore;
  end

  // fetch assumes not-taken, so any taken branch or jump redirects.
  assign redirect.taken = inValid &&
    (decoded.isJump || (decoded.isBranch && equal == decoded.branchOnEqual));
  assign redirect.target = decoded.pc + decoded.imm;

endmodule

`default_nettype wire

// ==== fetchStage.sv ====
`default_nettype none

module fetchStage #(
  parameter int imemWords = 256
) (
  input var logic clk,
  input var logic reset,
  input var logic imemWrite,
  input var logic [$clog2(imemWords)-1:0] imemAddress,
  input var isaPkg::wordT imemData,
  input var logic stall,
  input var pipePkg::redirectT redirect,
  output pipePkg::fetchDecodeT fetched,
  output logic fetchedValid
);

  localparam int indexBits = $clog2(imemWords);

  isaPkg::wordT imem [imemWords];
  isaPkg::wordT pc;

  always_ff @(posedge clk) begin
    if (imemWrite) begin
      imem[imemAddress] <= imemData;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (redirect.taken) begin
      pc <= redirect.target; // a redirect overrides a stall.
    end else if (!stall) begin
      pc <= pc + 32'd4;
    end
  end

  assign fetched.pc = pc;
  assign fetched.instruction = imem[pc[indexBits+1:2]];
  assign fetchedValid = pc[31:2] < 30'(imemWords); // nothing valid past the end.

  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hazardController.sv ====
`default_nettype none

module hazardController (
  input var isaPkg::regIndexT decodeRs1,
  input var isaPkg::regIndexT decodeRs2,
  input var pipePkg::decodeExecuteT executeEntry,
  input var logic executeValid,
  input var pipePkg::executeMemoryT memoryEntry,
  input var logic memoryValid,
  input var pipePkg::writebackT writebackEntry,
  input var logic writebackValid,
  input var pipePkg::redirectT redirect,
  output pipePkg::hazardCtrlT control
);

  logic loadUse;

  // decode sources of x0 are unused, so a nonzero rd is enough here.
  assign loadUse = executeValid && executeEntry.isLoad && executeEntry.rd != '0 &&
    (executeEntry.rd == decodeRs1 || executeEntry.rd == decodeRs2);

  // memory is the younger producer and wins over writeback.
  function automatic pipePkg::forwardSelT selectSource(isaPkg::regIndexT source);
    if (!executeValid || source == '0) return pipePkg::fromRegister;
    if (memoryValid && memoryEntry.writesReg && memoryEntry.rd == source) begin
      return pipePkg::fromMemory;
    end
    if (writebackValid && writebackEntry.writesReg && writebackEntry.rd == source) begin
      return pipePkg::fromWriteback;
    end
    return pipePkg::fromRegister;
  endfunction

  always_comb begin
    control.flushFront = redirect.taken;
    control.stallFront = loadUse;
    control.bubbleExecute = loadUse && !redirect.taken; // a flush already empties execute.
    control.rs1Forward = selectSource(executeEntry.rs1);
    control.rs2Forward = selectSource(executeEntry.rs2);
  end

  always_comb begin
    if (control.bubbleExecute) begin
      assert (control.stallFront) else $error("execute bubble without a front stall");
    end
  end

endmodule

`default_nettype wire

// ==== isaPkg.sv ====
`default_nettype none

package isaPkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0] regIndexT;

  // major opcodes of the supported subset. Any other value decodes as a no-op.
  typedef enum logic [6:0] {
    opcodeOp     = 7'b0110011,
    opcodeOpImm  = 7'b0010011,
    opcodeLui    = 7'b0110111,
    opcodeLoad   = 7'b0000011,
    opcodeStore  = 7'b0100011,
    opcodeBranch = 7'b1100011,
    opcodeJal    = 7'b1101111
  } opcodeT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluPassB
  } aluOpT;

  localparam logic [2:0] funct3AddSub = 3'b000;
  localparam logic [2:0] funct3Xor = 3'b100;
  localparam logic [2:0] funct3Or = 3'b110;
  localparam logic [2:0] funct3And = 3'b111;
  localparam logic [2:0] funct3Word = 3'b010; // width field of LW and SW.
  localparam logic [2:0] funct3Beq = 3'b000;
  localparam logic [2:0] funct3Bne = 3'b001;
  localparam logic [6:0] funct7Base = 7'b0000000;
  localparam logic [6:0] funct7Sub = 7'b0100000;

endpackage

`default_nettype wire

// ==== memoryStage.sv ====
`default_nettype none

module memoryStage #(
  parameter int dmemWords = 256,
  parameter isaPkg::wordT consoleAddress = 32'h0000_1000
) (
  input var logic clk,
  input var logic reset,
  input var pipePkg::executeMemoryT access,
  input var logic inValid,
  output pipePkg::writebackT retired,
  output logic consoleValid,
  output isaPkg::wordT consoleData
);

  localparam int indexBits = $clog2(dmemWords);

  isaPkg::wordT dmem [dmemWords];
  logic [indexBits-1:0] index;
  logic isConsole;
  logic consoleStore;

  assign index = access.aluResult[indexBits+1:2];
  assign isConsole = access.aluResult == consoleAddress;
  assign consoleStore = inValid && access.isStore && isConsole;

  // console stores go to the strobe and leave data memory untouched.
  always_ff @(posedge clk) begin
    if (inValid && access.isStore && !isConsole) begin
      dmem[index] <= access.storeValue;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      consoleValid <= 1'b0;
    end else begin
      consoleValid <= consoleStore;
    end
  end

  always_ff @(posedge clk) begin
    if (consoleStore) begin
      consoleData <= access.storeValue;
    end
  end

  always_comb begin
    retired.rd = access.rd;
    retired.writesReg = access.writesReg;
    retired.value = access.isLoad ? dmem[index] : access.aluResult;
  end

  // the address comes from the forwarded execute operands.
  assert property (@(posedge clk) disable iff (reset)
    (inValid && (access.isLoad || access.isStore) && !isConsole) |->
      access.aluResult[31:2] < 30'(dmemWords));

endmodule

`default_nettype wire

// ==== pipePkg.sv ====
`default_nettype none

package pipePkg;

  typedef struct packed {
    isaPkg::wordT pc;
    isaPkg::wordT instruction;
  } fetchDecodeT;

  // source indexes are zero when the instruction does not read that operand.
  typedef struct packed {
    isaPkg::wordT pc;
    isaPkg::aluOpT aluOp;
    isaPkg::regIndexT rs1;
    isaPkg::regIndexT rs2;
    isaPkg::wordT rs1Value;
    isaPkg::wordT rs2Value;
    isaPkg::wordT imm;
    isaPkg::regIndexT rd;
    logic writesReg;
    logic useImm;
    logic isLoad;
    logic isStore;
    logic isBranch;
    logic branchOnEqual;
    logic isJump;
  } decodeExecuteT;

  typedef struct packed {
    isaPkg::wordT aluResult; // doubles as the memory address.
    isaPkg::wordT storeValue;
    isaPkg::regIndexT rd;
    logic writesReg;
    logic isLoad;
    logic isStore;
  } executeMemoryT;

  typedef struct packed {
    isaPkg::regIndexT rd;
    logic writesReg;
    isaPkg::wordT value;
  } writebackT;

  typedef struct packed {
    logic taken;
    isaPkg::wordT target;
  } redirectT;

  typedef enum logic [1:0] {
    fromRegister,
    fromMemory,
    fromWriteback
  } forwardSelT;

  typedef struct packed {
    logic stallFront;
    logic bubbleExecute;
    logic flushFront;
    forwardSelT rs1Forward;
    forwardSelT rs2Forward;
  } hazardCtrlT;

endpackage

`default_nettype wire

// ==== project.f ====
isaPkg.sv
pipePkg.sv
stageRegister.sv
fetchStage.sv
registerFile.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazardController.sv
risky2.sv
tbClock.sv
risky2Tb.sv

// ==== registerFile.sv ====
`default_nettype none

module registerFile (
  input var logic clk,
  input var logic reset,
  input var isaPkg::regIndexT rs1,
  input var isaPkg::regIndexT rs2,
  output isaPkg::wordT rs1Value,
  output isaPkg::wordT rs2Value,
  input var pipePkg::writebackT write,
  input var logic writeValid
);

  isaPkg::wordT registers [32];
  logic writing;

  assign writing = writeValid && write.writesReg && write.rd != '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        registers[i] <= '0;
      end
    end else if (writing) begin
      registers[write.rd] <= write.value;
    end
  end

  // the word being written this cycle is returned to a matching read.
  function automatic isaPkg::wordT readPort(isaPkg::regIndexT index);
    if (index == '0) return '0;
    if (writing && write.rd == index) return write.value;
    return registers[index];
  endfunction

  always_comb begin
    rs1Value = readPort(rs1);
    rs2Value = readPort(rs2);
  end

endmodule

`default_nettype wire

// ==== risky2.sv ====
`default_nettype none

module risky2 #(
  parameter int imemWords = 256,
  parameter int dmemWords = 256,
  parameter isaPkg::wordT consoleAddress = 32'h0000_1000
) (
  input var logic clk,
  input var logic reset,
  input var logic imemWrite,
  input var logic [$clog2(imemWords)-1:0] imemAddress,
  input var isaPkg::wordT imemData,
  output logic consoleValid,
  output isaPkg::wordT consoleData
);

  pipePkg::fetchDecodeT fetched;
  pipePkg::fetchDecodeT fdData;
  pipePkg::decodeExecuteT decoded;
  pipePkg::decodeExecuteT deData;
  pipePkg::executeMemoryT executed;
  pipePkg::executeMemoryT emData;
  pipePkg::writebackT retired;
  pipePkg::writebackT mwData;
  pipePkg::redirectT redirect;
  pipePkg::hazardCtrlT control;
  isaPkg::regIndexT decodeRs1;
  isaPkg::regIndexT decodeRs2;
  logic fetchedValid;
  logic fdValid;
  logic deValid;
  logic emValid;
  logic mwValid;

  fetchStage #(.imemWords(imemWords)) fetchStage_i (
    .clk(clk),
    .reset(reset),
    .imemWrite(imemWrite),
    .imemAddress(imemAddress),
    .imemData(imemData),
    .stall(control.stallFront),
    .redirect(redirect),
    .fetched(fetched),
    .fetchedValid(fetchedValid)
  );

  stageRegister #(.payloadT(pipePkg::fetchDecodeT)) fetchDecodeReg (
    .clk(clk),
    .reset(reset),
    .hold(control.stallFront),
    .clear(control.flushFront),
    .inValid(fetchedValid),
    .inData(fetched),
    .outValid(fdValid),
    .outData(fdData)
  );

  decodeStage decodeStage_i (
    .clk(clk),
    .reset(reset),
    .fetched(fdData),
    .regWrite(mwData),
    .regWriteValid(mwValid),
    .decoded(decoded),
    .rs1(decodeRs1),
    .rs2(decodeRs2)
  );

  // a load-use stall leaves a bubble behind the load.
  stageRegister #(.payloadT(pipePkg::decodeExecuteT)) decodeExecuteReg (
    .clk(clk),
    .reset(reset),
    .hold(1'b0),
    .clear(control.flushFront || control.bubbleExecute),
    .inValid(fdValid),
    .inData(decoded),
    .outValid(deValid),
    .outData(deData)
  );

  executeStage executeStage_i (
    .decoded(deData),
    .rs1Forward(control.rs1Forward),
    .rs2Forward(control.rs2Forward),
    .memoryValue(emData.aluResult),
    .writebackValue(mwData.value),
    .inValid(deValid),
    .result(executed),
    .redirect(redirect)
  );

  stageRegister #(.payloadT(pipePkg::executeMemoryT)) executeMemoryReg (
    .clk(clk),
    .reset(reset),
    .hold(1'b0),
    .clear(1'b0),
    .inValid(deValid),
    .inData(executed),
    .outValid(emValid),
    .outData(emData)
  );

  memoryStage #(
    .dmemWords(dmemWords),
    .consoleAddress(consoleAddress)
  ) memoryStage_i (
    .clk(clk),
    .reset(reset),
    .access(emData),
    .inValid(emValid),
    .retired(retired),
    .consoleValid(consoleValid),
    .consoleData(consoleData)
  );

  stageRegister #(.payloadT(pipePkg::writebackT)) memoryWritebackReg (
    .clk(clk),
    .reset(reset),
    .hold(1'b0),
    .clear(1'b0),
    .inValid(emValid),
    .inData(retired),
    .outValid(mwValid),
    .outData(mwData)
  );

  hazardController hazardController_i (
    .decodeRs1(decodeRs1),
    .decodeRs2(decodeRs2),
    .executeEntry(deData),
    .executeValid(deValid),
    .memoryEntry(emData),
    .memoryValid(emValid),
    .writebackEntry(mwData),
    .writebackValid(mwValid),
    .redirect(redirect),
    .control(control)
  );

endmodule

`default_nettype wire

// ==== risky2Tb.sv ====
`default_nettype none

module risky2Tb;

  localparam int clockPeriod = 8;
  localparam int imemWords = 256;
  localparam int dmemWords = 256;
  localparam int addrBits = $clog2(imemWords);
  localparam int maxTests = 8;
  localparam int maxInstr = 24;
  localparam int maxWords = 8;
  localparam logic [6:0] opImm = 7'b0010011;
  localparam logic [6:0] opLoad = 7'b0000011;

  logic clk;
  logic reset;
  logic imemWrite;
  logic [addrBits-1:0] imemAddress;
  isaPkg::wordT imemData;
  logic consoleValid;
  isaPkg::wordT consoleData;

  string testName [maxTests];
  isaPkg::wordT code [maxTests][maxInstr];
  int codeLength [maxTests];
  isaPkg::wordT expected [maxTests][maxWords];
  int expectedCount [maxTests];
  int resetAfter [maxTests]; // cycles into the run before a second reset, zero for none.
  int testCount = 0;
  isaPkg::wordT observed [maxWords];
  int errorCount = 0;
  int passCount = 0;
  int failCount = 0;
  bit tableReady = 1'b0;

  tbClock #(.period(clockPeriod)) tbClock_i (.clk(clk));

  risky2 #(
    .imemWords(imemWords),
    .dmemWords(dmemWords),
    .consoleAddress(32'h0000_1000)
  ) dut_i (
    .clk(clk),
    .reset(reset),
    .imemWrite(imemWrite),
    .imemAddress(imemAddress),
    .imemData(imemData),
    .consoleValid(consoleValid),
    .consoleData(consoleData)
  );

  function automatic isaPkg::wordT encodeR(int funct7, int rs2, int rs1, int funct3, int rd);
    return {7'(funct7), 5'(rs2), 5'(rs1), 3'(funct3), 5'(rd), 7'b0110011};
  endfunction

  function automatic isaPkg::wordT encodeI(int imm, int rs1, int funct3, int rd,
                                           logic [6:0] opcode);
    return {12'(imm), 5'(rs1), 3'(funct3), 5'(rd), opcode};
  endfunction

  function automatic isaPkg::wordT encodeLui(int rd, int upper);
    return {20'(upper), 5'(rd), 7'b0110111};
  endfunction

  function automatic isaPkg::wordT encodeSw(int rs2, int rs1, int offset);
    logic [11:0] o;
    o = 12'(offset);
    return {o[11:5], 5'(rs2), 5'(rs1), 3'b010, o[4:0], 7'b0100011};
  endfunction

  function automatic isaPkg::wordT encodeBranch(int funct3, int rs1, int rs2, int offset);
    logic [12:0] o;
    o = 13'(offset);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(funct3), o[4:1], o[11], 7'b1100011};
  endfunction

  function automatic isaPkg::wordT encodeJal(int rd, int offset);
    logic [20:0] o;
    o = 21'(offset);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
  endfunction

  task automatic startTest(string name, int restartAfter);
    testName[testCount] = name;
    codeLength[testCount] = 0;
    expectedCount[testCount] = 0;
    resetAfter[testCount] = restartAfter;
    testCount++;
  endtask

  task automatic addInstr(isaPkg::wordT word);
    int t;
    t = testCount - 1;
    code[t][codeLength[t]] = word;
    codeLength[t]++;
  endtask

  task automatic addExpected(isaPkg::wordT word);
    int t;
    t = testCount - 1;
    expected[t][expectedCount[t]] = word;
    expectedCount[t]++;
  endtask

  // x31 holds the console address in every program.
  task automatic printReg(int rs);
    addInstr(encodeSw(rs, 31, 0));
  endtask

  task automatic buildAluChain(string name);
    logic [19:0] aHi;
    logic [19:0] bHi;
    logic [11:0] aLo;
    logic [11:0] bLo;
    isaPkg::wordT a;
    isaPkg::wordT b;
    isaPkg::wordT r3;
    isaPkg::wordT r4;
    isaPkg::wordT r5;
    isaPkg::wordT r6;
    isaPkg::wordT r7;
    aHi = 20'($urandom);
    aLo = 12'($urandom);
    bHi = 20'($urandom);
    bLo = 12'($urandom);
    a = {aHi, 12'b0} + {{20{aLo[11]}}, aLo}; // LUI then ADDI with a sign-extended immediate.
    b = {bHi, 12'b0} + {{20{bLo[11]}}, bLo};
    r3 = a + b;
    r4 = r3 - a;
    r5 = r4 & r3;
    r6 = r5 | b;
    r7 = r6 ^ r5;
    startTest(name, 0);
    addInstr(encodeLui(31, 1));
    addInstr(encodeLui(1, aHi));
    addInstr(encodeI(aLo, 1, 0, 1, opImm));
    addInstr(encodeLui(2, bHi));
    addInstr(encodeI(bLo, 2, 0, 2, opImm));
    addInstr(encodeR(0, 2, 1, 0, 3));
    addInstr(encodeR(32, 1, 3, 0, 4));
    addInstr(encodeR(0, 3, 4, 7, 5)); // x4 from memory, x3 from writeback.
    addInstr(encodeR(0, 2, 5, 6, 6));
    addInstr(encodeR(0, 5, 6, 4, 7));
    for (int r = 3; r <= 7; r++) begin
      printReg(r);
    end
    addInstr(encodeJal(0, 0));
    addExpected(r3);
    addExpected(r4);
    addExpected(r5);
    addExpected(r6);
    addExpected(r7);
  endtask

  task automatic buildLoadStore();
    logic [19:0] hi;
    logic [11:0] lo;
    isaPkg::wordT v;
    hi = 20'($urandom);
    lo = 12'($urandom);
    v = {hi, 12'b0} + {{20{lo[11]}}, lo};
    startTest("store then load", 0);
    addInstr(encodeLui(31, 1));
    addInstr(encodeLui(1, hi));
    addInstr(encodeI(lo, 1, 0, 1, opImm));
    addInstr(encodeI(16, 0, 0, 2, opImm));
    addInstr(encodeSw(1, 2, 0));
    addInstr(encodeI(0, 2, 2, 3, opLoad));
    addInstr(encodeI(1, 3, 0, 4, opImm)); // uses the load right away.
    printReg(4);
    printReg(3);
    addInstr(encodeI(0, 2, 2, 5, opLoad));
    printReg(5);
    addInstr(encodeJal(0, 0));
    addExpected(v + 32'd1);
    addExpected(v);
    addExpected(v);
  endtask

  task automatic buildBranches();
    startTest("branches", 0);
    addInstr(encodeLui(31, 1));
    addInstr(encodeI(5, 0, 0, 1, opImm));
    addInstr(encodeI(5, 0, 0, 2, opImm));
    addInstr(encodeI(7, 0, 0, 3, opImm));
    addInstr(encodeBranch(0, 1, 2, 12)); // taken BEQ over two stores.
    printReg(1);
    printReg(2);
    addInstr(encodeBranch(1, 1, 3, 12)); // taken BNE over two stores.
    printReg(3);
    printReg(3);
    addInstr(encodeBranch(0, 1, 3, 8));
    printReg(1);
    addInstr(encodeBranch(1, 1, 2, 8));
    printReg(3);
    addInstr(encodeJal(0, 0));
    addExpected(32'd5);
    addExpected(32'd7);
  endtask

  task automatic buildJal();
    startTest("jal link and x0", 0);
    addInstr(encodeLui(31, 1));
    addInstr(encodeJal(1, 8)); // at pc 4, lands on pc 12.
    printReg(0);
    printReg(1);
    addInstr(encodeI(123, 0, 0, 0, opImm));
    printReg(0);
    addInstr(encodeR(0, 1, 1, 0, 0));
    addInstr(encodeR(0, 1, 0, 0, 2));
    printReg(2);
    addInstr(encodeJal(0, 0));
    addExpected(32'd4 + 32'd4);
    addExpected(32'd0);
    addExpected(32'd8);
  endtask

  // the second reset is sampled while the third store sits in the memory stage.
  task automatic buildRestart();
    startTest("reset mid program", 8);
    addInstr(encodeLui(31, 1));
    for (int i = 0; i < 3; i++) begin
      addInstr(encodeI(1, (i == 0) ? 0 : 1, 0, 1, opImm));
      printReg(1);
      addExpected(isaPkg::wordT'(i + 1));
    end
    addInstr(encodeJal(0, 0));
  endtask

  function automatic int totalBudgetCycles();
    int sum;
    sum = 0;
    for (int t = 0; t < testCount; t++) begin
      sum += 40 + 4 * codeLength[t] + 2 * (codeLength[t] + 10) + resetAfter[t] + 10;
    end
    return sum;
  endfunction

  task automatic checkValue(string name, isaPkg::wordT expectedValue,
                            isaPkg::wordT actualValue);
    if (actualValue !== expectedValue) begin
      $display("** Error: %s expected %h actual %h", name, expectedValue, actualValue);
      errorCount++;
    end
  endtask

  // reset stays high for at least 8 cycles and long enough to load the program.
  task automatic holdReset(int t, bit load);
    int span;
    span = (load && codeLength[t] > 7) ? codeLength[t] : 7;
    @(posedge clk);
    reset <= 1'b1;
    for (int c = 0; c < span; c++) begin
      @(posedge clk);
      if (load && c < codeLength[t]) begin
        imemWrite <= 1'b1;
        imemAddress <= addrBits'(c);
        imemData <= code[t][c];
      end else begin
        imemWrite <= 1'b0;
      end
      @(negedge clk);
      if (consoleValid) begin
        $display("%s: console strobe seen while reset was high", testName[t]);
        errorCount++;
      end
    end
    @(posedge clk);
    reset <= 1'b0;
    imemWrite <= 1'b0;
  endtask

  task automatic collectConsole(int t, output int got);
    int budget;
    int cycles;
    budget = 40 + 4 * codeLength[t];
    cycles = 0;
    got = 0;
    while (got < expectedCount[t] && cycles < budget) begin
      @(negedge clk);
      cycles++;
      if (consoleValid) begin
        observed[got] = consoleData;
        got++;
      end
    end
  endtask

  task automatic runTest(int t);
    int errorsBefore;
    int got;
    errorsBefore = errorCount;
    holdReset(t, 1'b1);
    if (resetAfter[t] > 0) begin
      repeat (resetAfter[t]) @(posedge clk);
      holdReset(t, 1'b0); // strobes from the first partial run are dropped.
    end
    collectConsole(t, got);
    if (got < expectedCount[t]) begin
      $display("%s: only %0d of %0d console words arrived before the budget ran out",
               testName[t], got, expectedCount[t]);
      errorCount++;
    end
    for (int i = 0; i < got; i++) begin
      checkValue($sformatf("%s word %0d", testName[t], i), expected[t][i], observed[i]);
    end
    if (errorCount == errorsBefore) begin
      passCount++;
      $display("%s: passed", testName[t]);
    end else begin
      failCount++;
      $display("%s: failed", testName[t]);
    end
  endtask

  initial begin
    reset = 1'b1;
    imemWrite = 1'b0;
    imemAddress = '0;
    imemData = '0;
    void'($urandom(32'hcce9_1e61));
    buildAluChain("alu chain a");
    buildAluChain("alu chain b");
    buildLoadStore();
    buildBranches();
    buildJal();
    buildRestart();
    tableReady = 1'b1;
    for (int t = 0; t < testCount; t++) begin
      runTest(t);
    end
    $display("%0d tests passed, %0d tests failed", passCount, failCount);
    if (failCount == 0 && errorCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    int limit;
    wait (tableReady);
    limit = totalBudgetCycles();
    #(limit * clockPeriod);
    $display("watchdog: the run went past %0d cycles without finishing", limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Builds and runs the risky2 testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module risky2Tb -f project.f \
  -o risky2Sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/risky2Sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

// ==== stageRegister.sv ====
`default_nettype none

module stageRegister #(
  parameter type payloadT = logic
) (
  input var logic clk,
  input var logic reset,
  input var logic hold,
  input var logic clear,
  input var logic inValid,
  input var payloadT inData,
  output logic outValid,
  output payloadT outData
);

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      outValid <= 1'b0; // clear wins over hold.
    end else if (!hold) begin
      outValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold) begin
      outData <= inData;
    end
  end

  // a held entry must not change under the stage that consumes it.
  assert property (@(posedge clk) disable iff (reset)
    (hold && !clear && outValid) |=> $stable(outData));

endmodule

`default_nettype wire

// ==== tbClock.sv ====
`default_nettype none

module tbClock #(
  parameter int period = 8
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire
